// File: branch_condition.sv
`timescale 1ns/100ps

module branch_condition (
	input  legv8_isa_pkg::insn_u      insn,
	input  legv8_isa_pkg::alu_flags_t status,
	input  legv8_isa_pkg::alu_flags_t flags,
	output logic                      taken_cond,
	output logic                      taken_cbz
);
	import legv8_isa_pkg::*;

	cond_code_t cond;

	// condition code sits in the rt slot of the CB format
	assign cond = cond_code_t'(insn.cb.rt[3:0]);

	// B.cond against the latched flags
	always_comb begin
		case (cond)
			CC_EQ: taken_cond = status.z;
			CC_NE: taken_cond = ~status.z;
			CC_HS: taken_cond = status.c;
			CC_LO: taken_cond = ~status.c;
			CC_MI: taken_cond = status.n;
			CC_PL: taken_cond = ~status.n;
			CC_VS: taken_cond = status.v;
			CC_VC: taken_cond = ~status.v;
			// unsigned compares
			CC_HI: taken_cond = status.c & ~status.z;
			CC_LS: taken_cond = ~status.c | status.z;
			// signed compares, n == v means greater or equal
			CC_GE: taken_cond = ~(status.n ^ status.v);
			CC_LT: taken_cond = status.n ^ status.v;
			CC_GT: taken_cond = ~status.z & ~(status.n ^ status.v);
			CC_LE: taken_cond = status.z | (status.n ^ status.v);
			CC_AL: taken_cond = 1'b1;
			default: taken_cond = 1'b0;
		endcase
	end

	// bit 24 clear for CBZ, set for CBNZ
	// zero flag is live, rt goes through the ALU in the same cycle
	assign taken_cbz = insn.raw[24] ^ flags.z;

endmodule

// File: constant_generator.sv
`timescale 1ns/100ps
`include "legv8_settings.svh"

module constant_generator (
	input  legv8_isa_pkg::insn_u       insn,
	input  legv8_ctrl_pkg::const_sel_t cgs,
	output logic [`LEGV8_DATA_WIDTH-1:0] constant
);
	import legv8_isa_pkg::*;
	import legv8_ctrl_pkg::*;

	always_comb begin
		case (cgs)
			CS_IMM12: constant = {{(`LEGV8_DATA_WIDTH-12){1'b0}}, insn.i.imm12};
			CS_IMM16: constant = {{(`LEGV8_DATA_WIDTH-16){1'b0}}, insn.iw.imm16};
			// clears the low half word ahead of the MOVK merge
			CS_MOVK_MASK: constant = {{(`LEGV8_DATA_WIDTH-16){1'b1}}, 16'h0000};
			// branch offsets in words, shifted later by the PC adder
			CS_BR26: constant = {{(`LEGV8_DATA_WIDTH-26){insn.b.br_address[25]}},
				insn.b.br_address};
			CS_BR19: constant = {{(`LEGV8_DATA_WIDTH-19){insn.cb.cond_br_address[18]}},
				insn.cb.cond_br_address};
			CS_DT9: constant = {{(`LEGV8_DATA_WIDTH-9){insn.d.dt_address[8]}},
				insn.d.dt_address};
			CS_SHAMT: constant = {{(`LEGV8_DATA_WIDTH-6){1'b0}}, insn.r.shamt};
			default: constant = '0;
		endcase
	end

	// known word and select give a known constant, the IR is cleared by reset
	a_constant_known: assert final ($isunknown({insn.raw, cgs}) || !$isunknown(constant))
		else $error("unknown constant from a known instruction");

endmodule

// File: control_state_regs.sv
`timescale 1ns/100ps
`include "legv8_settings.svh"

module control_state_regs (
	input  logic                                clock,
	input  logic                                rst_n,
	input  logic [`LEGV8_INSN_WIDTH-1:0]        instruction,
	input  legv8_isa_pkg::alu_flags_t           flags,
	input  legv8_ctrl_pkg::control_word_t       control_word,
	output legv8_ctrl_pkg::ctrl_state_t         state,
	output legv8_isa_pkg::insn_u                insn,
	output legv8_isa_pkg::alu_flags_t           status
);
	import legv8_isa_pkg::*;
	import legv8_ctrl_pkg::*;

	// state follows ns every cycle
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= ST_IF;
		end else begin
			state <= control_word.ns;
		end
	end

	// instruction register, loaded only by the fetch word
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			insn.raw <= '0;
		end else if (control_word.il) begin
			insn.raw <= instruction;
		end
	end

	// status register for B.cond
	// flags of the cycle with sl set
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			status <= '0;
		end else if (control_word.sl) begin
			status <= flags;
		end
	end

	// decoder must never steer into the free encoding
	a_state_legal: assert property (@(posedge clock) disable iff (!rst_n)
		state inside {ST_IF, ST_EX0, ST_EX1})
		else $error("control state holds an unused encoding");

	// instruction load belongs to fetch only
	a_il_in_fetch: assert property (@(posedge clock) disable iff (!rst_n)
		control_word.il |-> state == ST_IF)
		else $error("instruction load outside of fetch");

endmodule

// File: control_word_decoder.sv
`timescale 1ns/100ps
`include "legv8_settings.svh"

module control_word_decoder (
	input  legv8_ctrl_pkg::ctrl_state_t   state,
	input  legv8_isa_pkg::insn_u          insn,
	input  logic                          taken_cond,
	input  logic                          taken_cbz,
	output legv8_ctrl_pkg::control_word_t control_word
);
	import legv8_isa_pkg::*;
	import legv8_ctrl_pkg::*;

	// 00 data imm, 01 branch, 10 memory, 11 data reg
	logic [1:0] ex0_class;
	// 00 B/BL, 01 CBZ/CBNZ, 10 B.cond, 11 BR
	logic [1:0] branch_class;
	logic       ldst_match;
	logic [1:0] logic_op;
	logic       ands;

	// opcode class from bits 27..25
	assign ex0_class[1] = insn.raw[27];
	assign ex0_class[0] = (~insn.raw[27] & insn.raw[26]) | (insn.raw[27] & insn.raw[25]);

	// branch kind from bits 30, 29 and 25
	assign branch_class[1] = insn.raw[30] & ~insn.raw[29];
	assign branch_class[0] = (insn.raw[30] & ~insn.raw[29] & insn.raw[25]) |
		(~insn.raw[30] & insn.raw[29] & ~insn.raw[25]);

	// plain LDUR/STUR, the rest of the memory group is left out
	assign ldst_match = insn.raw[29] & insn.raw[28] & ~insn.raw[24] & ~insn.raw[21] &
		~insn.raw[11] & ~insn.raw[10];

	// AND 00, ORR 01, EOR 11, ANDS reuses AND
	always_comb begin
		case (insn.raw[30:29])
			2'b01: logic_op = 2'b01;
			2'b10: logic_op = 2'b11;
			default: logic_op = 2'b00;
		endcase
	end

	// ANDS alone sets flags in the logical group
	assign ands = insn.raw[30] & insn.raw[29];

	always_comb begin
		// unlisted forms fall through as an all zero word
		control_word = '0;
		case (state)
			ST_IF: begin
				// memory read at PC into IR, PC + 4
				control_word.ns   = ST_EX0;
				control_word.as   = 1'b1;
				control_word.ds   = 2'b11;
				control_word.ps   = 2'b01;
				control_word.il   = 1'b1;
				control_word.size = 2'b11;
			end
			ST_EX1: begin
				// MOVK second half, OR imm16 into the masked rd
				control_word.cgs  = CS_IMM16;
				control_word.ns   = ST_IF;
				control_word.b_sel = 1'b1;
				control_word.fs   = 5'b00100;
				control_word.size = {1'b1, insn.raw[31]};
				control_word.rw   = 1'b1;
				control_word.da   = insn.iw.rd;
				control_word.sa   = insn.iw.rd;
			end
			ST_EX0: begin
				case (ex0_class)
					2'b00: begin
						// data immediate, all write rd and use the constant
						control_word.b_sel = 1'b1;
						control_word.size  = {1'b1, insn.raw[31]};
						case (insn.raw[25:23])
							3'b010: begin
								// ADDI/SUBI, bit 30 subtracts, bit 29 sets flags
								control_word.cgs = CS_IMM12;
								control_word.sl  = insn.raw[29];
								control_word.fs  = {4'b0100, insn.raw[30]};
								control_word.c0  = insn.raw[30];
								control_word.rw  = 1'b1;
								control_word.da  = insn.i.rd;
								control_word.sa  = insn.i.rn;
							end
							3'b100: begin
								control_word.cgs = CS_IMM12;
								control_word.sl  = ands;
								control_word.fs  = {1'b0, logic_op, 2'b00};
								control_word.rw  = 1'b1;
								control_word.da  = insn.i.rd;
								control_word.sa  = insn.i.rn;
							end
							3'b101: begin
								// MOVZ ORs imm16 with zr
								// MOVK ANDs rd with the mask first, then EX1
								control_word.cgs = insn.raw[29] ? CS_MOVK_MASK : CS_IMM16;
								control_word.ns  = insn.raw[29] ? ST_EX1 : ST_IF;
								control_word.fs  = {2'b00, ~insn.raw[29], 2'b00};
								control_word.rw  = 1'b1;
								control_word.da  = insn.iw.rd;
								control_word.sa  = insn.raw[29] ? insn.iw.rd : `LEGV8_REG_ZR;
							end
							default: begin
								// bitfield, extract
								control_word = '0;
							end
						endcase
					end
					2'b01: begin
						case (branch_class)
							2'b00: begin
								// B/BL, BL saves PC in LR
								control_word.cgs    = CS_BR26;
								control_word.ds     = 2'b10;
								control_word.ps     = 2'b11;
								control_word.pc_sel = 1'b1;
								control_word.rw     = insn.raw[31];
								control_word.da     = `LEGV8_REG_LR;
							end
							2'b01: begin
								// rt passes through the ALU, zero flag decides
								control_word.cgs    = CS_BR19;
								control_word.ps     = {taken_cbz, taken_cbz};
								control_word.pc_sel = 1'b1;
								control_word.fs     = 5'b01000;
								control_word.size   = 2'b11;
								control_word.sa     = `LEGV8_REG_ZR;
								control_word.sb     = insn.cb.rt;
							end
							2'b10: begin
								control_word.cgs    = CS_BR19;
								control_word.ps     = {taken_cond, taken_cond};
								control_word.pc_sel = 1'b1;
							end
							default: begin
								// BR, PC from rn
								control_word.ps = 2'b10;
								control_word.sa = insn.r.rn;
							end
						endcase
					end
					2'b10: begin
						if (ldst_match) begin
							// bit 22 set for LDUR
							control_word.cgs   = CS_DT9;
							control_word.ds    = {insn.raw[22], 1'b1};
							control_word.b_sel = 1'b1;
							control_word.fs    = 5'b01000;
							control_word.size  = insn.raw[31:30];
							control_word.mw    = ~insn.raw[22];
							control_word.rw    = insn.raw[22];
							control_word.da    = insn.d.rt;
							control_word.sa    = insn.d.rn;
							control_word.sb    = insn.d.rt;
						end
					end
					default: begin
						// data register, bit 28 and bit 24 pick the group
						control_word.cgs  = CS_SHAMT;
						control_word.size = {1'b1, insn.raw[31]};
						control_word.da   = insn.r.rd;
						control_word.sa   = insn.r.rn;
						control_word.sb   = insn.r.rm;
						case ({insn.raw[28], insn.raw[24]})
							2'b00: begin
								control_word.sl = ands;
								control_word.fs = {1'b0, logic_op, 2'b00};
								control_word.rw = 1'b1;
							end
							2'b01: begin
								control_word.sl = insn.raw[29];
								control_word.fs = {4'b0100, insn.raw[30]};
								control_word.c0 = insn.raw[30];
								control_word.rw = 1'b1;
							end
							default: begin
								// multiply and the rest
								control_word = '0;
							end
						endcase
					end
				endcase
			end
			default: begin
				control_word = '0;
			end
		endcase
	end

	// one memory access per cycle, load and store never together
	a_mw_rw_exclusive: assert final (!(control_word.mw && control_word.rw))
		else $error("memory write and register write both set");

endmodule

// File: legv8_control_unit.sv
`timescale 1ns/100ps
`include "legv8_settings.svh"

module legv8_control_unit (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic [`LEGV8_INSN_WIDTH-1:0]  instruction,
	input  legv8_isa_pkg::alu_flags_t     flags,
	output legv8_ctrl_pkg::control_word_t control_word,
	output logic [`LEGV8_DATA_WIDTH-1:0]  constant
);
	import legv8_isa_pkg::*;
	import legv8_ctrl_pkg::*;

	ctrl_state_t state;
	insn_u       insn;
	alu_flags_t  status;
	logic        taken_cond;
	logic        taken_cbz;

	// state, IR and status, steered by ns, il and sl
	control_state_regs u_regs (
		.clock        (clock),
		.rst_n        (rst_n),
		.instruction  (instruction),
		.flags        (flags),
		.control_word (control_word),
		.state        (state),
		.insn         (insn),
		.status       (status)
	);

	control_word_decoder u_decoder (
		.state        (state),
		.insn         (insn),
		.taken_cond   (taken_cond),
		.taken_cbz    (taken_cbz),
		.control_word (control_word)
	);

	// B.cond on latched status, CBZ/CBNZ on live zero flag
	branch_condition u_branch (
		.insn       (insn),
		.status     (status),
		.flags      (flags),
		.taken_cond (taken_cond),
		.taken_cbz  (taken_cbz)
	);

	constant_generator u_constant (
		.insn     (insn),
		.cgs      (control_word.cgs),
		.constant (constant)
	);

endmodule

// File: legv8_ctrl_pkg.sv
package legv8_ctrl_pkg;

	// microcode states, EX1 only for the MOVK merge
	typedef enum logic [1:0] {
		ST_IF  = 2'd0,
		ST_EX0 = 2'd1,
		ST_EX1 = 2'd2
	} ctrl_state_t;

	// constant generator select
	// encoding 1 left free
	typedef enum logic [2:0] {
		CS_IMM12     = 3'd0,
		CS_IMM16     = 3'd2,
		CS_MOVK_MASK = 3'd3,
		CS_BR26      = 3'd4,
		CS_BR19      = 3'd5,
		CS_DT9       = 3'd6,
		CS_SHAMT     = 3'd7
	} const_sel_t;

	// control word to the datapath, msb first
	typedef struct packed {
		// constant select and next state stay inside the control unit
		const_sel_t  cgs;
		ctrl_state_t ns;
		// address bus source, 1 = PC
		logic        as;
		// data bus source
		logic [1:0]  ds;
		// PC function, 00 hold, 01 increment, 10 load register, 11 add offset
		logic [1:0]  ps;
		logic        pc_sel;
		// ALU B input, 1 = constant
		logic        b_sel;
		// instruction load, status load
		logic        il;
		logic        sl;
		// ALU function and carry in
		logic [4:0]  fs;
		logic        c0;
		logic [1:0]  size;
		// memory write, register write
		logic        mw;
		logic        rw;
		// destination and the two source register numbers
		logic [4:0]  da;
		logic [4:0]  sa;
		logic [4:0]  sb;
	} control_word_t;

endpackage

// File: legv8_isa_pkg.sv
`include "legv8_settings.svh"

package legv8_isa_pkg;

	// register format, ADD/SUB/AND/ORR/EOR and BR
	typedef struct packed {
		logic [10:0] opcode;
		logic [4:0]  rm;
		logic [5:0]  shamt;
		logic [4:0]  rn;
		logic [4:0]  rd;
	} r_fmt_t;

	// immediate format, ADDI/SUBI and logical immediate
	typedef struct packed {
		logic [9:0]  opcode;
		logic [11:0] imm12;
		logic [4:0]  rn;
		logic [4:0]  rd;
	} i_fmt_t;

	// wide immediate, MOVZ/MOVK
	typedef struct packed {
		logic [8:0]  opcode;
		logic [1:0]  hw;
		logic [15:0] imm16;
		logic [4:0]  rd;
	} iw_fmt_t;

	// data transfer, LDUR/STUR
	typedef struct packed {
		logic [10:0] opcode;
		logic [8:0]  dt_address;
		logic [1:0]  op;
		logic [4:0]  rn;
		logic [4:0]  rt;
	} d_fmt_t;

	// unconditional branch, B/BL
	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] br_address;
	} b_fmt_t;

	// compare and branch, CBZ/CBNZ and B.cond
	// for B.cond the low four bits of rt hold the condition
	typedef struct packed {
		logic [7:0]  opcode;
		logic [18:0] cond_br_address;
		logic [4:0]  rt;
	} cb_fmt_t;

	// one latched word, read through whichever format the opcode class picks
	typedef union packed {
		r_fmt_t  r;
		i_fmt_t  i;
		iw_fmt_t iw;
		d_fmt_t  d;
		b_fmt_t  b;
		cb_fmt_t cb;
		logic [`LEGV8_INSN_WIDTH-1:0] raw;
	} insn_u;

	// ALU flags, same layout in the status register
	typedef struct packed {
		logic v;
		logic c;
		logic n;
		logic z;
	} alu_flags_t;

	// B.cond condition field
	typedef enum logic [3:0] {
		CC_EQ = 4'h0,
		CC_NE = 4'h1,
		CC_HS = 4'h2,
		CC_LO = 4'h3,
		CC_MI = 4'h4,
		CC_PL = 4'h5,
		CC_VS = 4'h6,
		CC_VC = 4'h7,
		CC_HI = 4'h8,
		CC_LS = 4'h9,
		CC_GE = 4'ha,
		CC_LT = 4'hb,
		CC_GT = 4'hc,
		CC_LE = 4'hd,
		CC_AL = 4'he,
		CC_NV = 4'hf
	} cond_code_t;

endpackage

// File: legv8_settings.svh
`ifndef LEGV8_SETTINGS_SVH
`define LEGV8_SETTINGS_SVH

// fetched instruction word
`define LEGV8_INSN_WIDTH 32

// datapath word, also the immediate constant handed to the ALU B input
`define LEGV8_DATA_WIDTH 64

// register 31 reads as zero
`define LEGV8_REG_ZR 5'd31

// BL writes the return address here
`define LEGV8_REG_LR 5'd30

`endif

// File: project.f
+incdir+.
legv8_isa_pkg.sv
legv8_ctrl_pkg.sv
control_state_regs.sv
control_word_decoder.sv
branch_condition.sv
constant_generator.sv
legv8_control_unit.sv
tb_legv8_control_unit.sv

// File: tb_legv8_control_unit.sv
`timescale 1ns/100ps
`include "legv8_settings.svh"

module tb_legv8_control_unit;
	import legv8_isa_pkg::*;
	import legv8_ctrl_pkg::*;

	// instruction count over all tests sets the cycle limit
	localparam int NUM_INSNS = 12 + 4 + 32 + 7 + 2;
	localparam int CYCLE_LIMIT = 3 * NUM_INSNS + 20;

	// immediate group with index 0 on the last entry
	// ANDS EORI ORRI ANDI SUBIS ADDI
	localparam logic [5:0][9:0] IMM_OPC = {10'b1111001000, 10'b1101001000, 10'b1011001000,
		10'b1001001000, 10'b1111000100, 10'b1001000100};
	localparam logic [5:0][4:0] IMM_FS = {5'b00000, 5'b01100, 5'b00100, 5'b00000,
		5'b01001, 5'b01000};
	localparam logic [5:0] IMM_C0 = 6'b000010;
	localparam logic [5:0] IMM_SL = 6'b100010;

	logic                         clock = 1'b0;
	logic                         rst_n;
	logic [`LEGV8_INSN_WIDTH-1:0] instruction;
	alu_flags_t                   flags;
	control_word_t                control_word;
	logic [`LEGV8_DATA_WIDTH-1:0] constant;

	logic [31:0] lcg_state = 32'h5c9c_b970;
	int          errors = 0;
	int          checks = 0;
	int          cycle_count = 0;

	legv8_control_unit u_legv8_control_unit (
		.clock        (clock),
		.rst_n        (rst_n),
		.instruction  (instruction),
		.flags        (flags),
		.control_word (control_word),
		.constant     (constant)
	);

	always #50 clock = ~clock;

	// watchdog on rising edges
	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// B.cond table over the latched flags
	function automatic logic cond_holds(input logic [3:0] code, input alu_flags_t f);
		logic ge;
		ge = (f.n == f.v);
		case (code)
			4'h0: return f.z;
			4'h1: return !f.z;
			4'h2: return f.c;
			4'h3: return !f.c;
			4'h4: return f.n;
			4'h5: return !f.n;
			4'h6: return f.v;
			4'h7: return !f.v;
			4'h8: return f.c && !f.z;
			4'h9: return !f.c || f.z;
			4'ha: return ge;
			4'hb: return !ge;
			4'hc: return !f.z && ge;
			4'hd: return f.z || !ge;
			4'he: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic expect_equal(input string what, input logic [63:0] got,
		input logic [63:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[ERROR] %0t: %s got %h expected %h", $time, what, got, expected);
		end
	endtask

	// drive point 10 ns after the rising edge
	task automatic next_cycle();
		@(posedge clock);
		#10;
	endtask

	task automatic verify_fetch();
		expect_equal("fetch il", control_word.il, 1'b1);
		expect_equal("fetch ps", control_word.ps, 2'b01);
		expect_equal("fetch ns", control_word.ns, ST_EX0);
		expect_equal("fetch mw", control_word.mw, 1'b0);
		expect_equal("fetch rw", control_word.rw, 1'b0);
	endtask

	// called in IF and returns at the drive point of EX0
	task automatic issue(input logic [31:0] word);
		instruction = word;
		@(negedge clock);
		verify_fetch();
		next_cycle();
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (7) @(posedge clock);
		@(negedge clock);
		verify_fetch();
		next_cycle();
		rst_n = 1'b1;
	endtask

	task automatic immediate_ops();
		logic [31:0] rnd;
		int round;
		int k;
		for (round = 0; round < 2; round++) begin
			for (k = 0; k < 6; k++) begin
				rnd = next_random();
				issue({IMM_OPC[k], rnd[21:10], rnd[26:22], rnd[31:27]});
				@(negedge clock);
				expect_equal("imm fs", control_word.fs, IMM_FS[k]);
				expect_equal("imm c0", control_word.c0, IMM_C0[k]);
				expect_equal("imm sl", control_word.sl, IMM_SL[k]);
				expect_equal("imm rw", control_word.rw, 1'b1);
				expect_equal("imm da", control_word.da, rnd[31:27]);
				expect_equal("imm sa", control_word.sa, rnd[26:22]);
				expect_equal("imm constant", constant, {52'd0, rnd[21:10]});
				next_cycle();
			end
		end
	endtask

	// bit 22 picks LDUR and bits 31..30 the access size
	task automatic load_store_ops();
		logic [31:0] rnd;
		logic        ld;
		int k;
		for (k = 0; k < 4; k++) begin
			rnd = next_random();
			ld = k[0];
			issue({rnd[31:30], 7'b1110000, ld, 1'b0, rnd[20:12], 2'b00, rnd[29:25], rnd[24:20]});
			@(negedge clock);
			expect_equal("mem mw", control_word.mw, !ld);
			expect_equal("mem rw", control_word.rw, ld);
			expect_equal("mem size", control_word.size, rnd[31:30]);
			expect_equal("mem constant", constant,
				{{(`LEGV8_DATA_WIDTH-9){rnd[20]}}, rnd[20:12]});
			next_cycle();
		end
	endtask

	task automatic cond_branch_ops();
		logic [31:0] rnd;
		alu_flags_t  latched;
		int code;
		for (code = 0; code < 16; code++) begin
			rnd = next_random();
			latched = alu_flags_t'(rnd[31:28]);
			// ADDS sets flags from this cycle
			issue({11'b10101011000, rnd[4:0], 6'd0, rnd[9:5], rnd[14:10]});
			flags = latched;
			@(negedge clock);
			expect_equal("adds sl", control_word.sl, 1'b1);
			next_cycle();
			// live flags differ so only the latched copy can match
			flags = ~latched;
			issue({8'b01010100, rnd[26:8], 1'b0, code[3:0]});
			@(negedge clock);
			expect_equal("bcond ps", control_word.ps, {2{cond_holds(code[3:0], latched)}});
			expect_equal("bcond constant", constant,
				{{(`LEGV8_DATA_WIDTH-19){rnd[26]}}, rnd[26:8]});
			next_cycle();
		end
	endtask

	task automatic compare_and_jump_ops();
		logic [31:0] rnd;
		logic        cbnz;
		logic        zero;
		logic        taken;
		int k;
		for (k = 0; k < 4; k++) begin
			rnd = next_random();
			cbnz = k[1];
			zero = k[0];
			issue({7'b1011010, cbnz, rnd[31:13], rnd[4:0]});
			flags = '0;
			flags.z = zero;
			@(negedge clock);
			taken = cbnz ? !zero : zero;
			expect_equal("cbz ps", control_word.ps, {taken, taken});
			expect_equal("cbz sb", control_word.sb, rnd[4:0]);
			expect_equal("cbz constant", constant,
				{{(`LEGV8_DATA_WIDTH-19){rnd[31]}}, rnd[31:13]});
			next_cycle();
		end
		// B then BL
		for (k = 0; k < 2; k++) begin
			rnd = next_random();
			issue({k[0], 5'b00101, rnd[31:6]});
			@(negedge clock);
			expect_equal("b rw", control_word.rw, k[0]);
			if (k[0]) begin
				expect_equal("bl da", control_word.da, `LEGV8_REG_LR);
			end
			expect_equal("b constant", constant,
				{{(`LEGV8_DATA_WIDTH-26){rnd[31]}}, rnd[31:6]});
			next_cycle();
		end
		rnd = next_random();
		issue({11'b11010110000, 5'b11111, 6'd0, rnd[31:27], 5'd0});
		@(negedge clock);
		expect_equal("br sa", control_word.sa, rnd[31:27]);
		next_cycle();
	endtask

	task automatic wide_move_ops();
		logic [31:0] rnd;
		rnd = next_random();
		issue({9'b110100101, 2'b00, rnd[31:16], rnd[4:0]});
		@(negedge clock);
		expect_equal("movz ns", control_word.ns, ST_IF);
		expect_equal("movz rw", control_word.rw, 1'b1);
		expect_equal("movz da", control_word.da, rnd[4:0]);
		expect_equal("movz constant", constant, {48'd0, rnd[31:16]});
		next_cycle();
		rnd = next_random();
		issue({9'b111100101, 2'b00, rnd[31:16], rnd[4:0]});
		// EX0 masks rd
		@(negedge clock);
		expect_equal("movk ns", control_word.ns, ST_EX1);
		expect_equal("movk mask", constant, 64'hffff_ffff_ffff_0000);
		next_cycle();
		// EX1 merges imm16
		@(negedge clock);
		expect_equal("movk ex1 ns", control_word.ns, ST_IF);
		expect_equal("movk ex1 rw", control_word.rw, 1'b1);
		expect_equal("movk ex1 da", control_word.da, rnd[4:0]);
		expect_equal("movk ex1 constant", constant, {48'd0, rnd[31:16]});
		next_cycle();
	endtask

	initial begin
		rst_n = 1'b0;
		instruction = '0;
		flags = '0;
		apply_reset();
		immediate_ops();
		load_store_ops();
		cond_branch_ops();
		compare_and_jump_ops();
		wide_move_ops();
		// back in fetch after the last MOVK
		@(negedge clock);
		verify_fetch();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
